//--- hdl/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define CORE_XLEN     32
`define CORE_NREGS    32
`define CORE_RESET_PC 32'h0000_0000

// Primary opcodes
`define OP_SPECIAL 6'h00
`define OP_J       6'h02
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// Function codes under OP_SPECIAL
`define FN_SLL  6'h00
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_SLT  6'h2a

`endif

//--- hdl/core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // Same word, register or immediate layout
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instruction_t;

    // One-hot ALU select
    typedef enum logic [6:0] {
        ADD = 7'b000_0001,
        SUB = 7'b000_0010,
        AND = 7'b000_0100,
        OR  = 7'b000_1000,
        SLT = 7'b001_0000,
        SLL = 7'b010_0000,
        LUI = 7'b100_0000
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    mem_read;
        logic    mem_write;
        logic    write_reg;
    } control_t;

    typedef struct packed {
        control_t              control;
        logic [`CORE_XLEN-1:0] operand_a;
        logic [`CORE_XLEN-1:0] operand_b;
        logic [`CORE_XLEN-1:0] store_data;
        logic [4:0]            rs;
        logic [4:0]            rt;
        logic [4:0]            dest_reg;
    } decode_out_t;

    typedef struct packed {
        control_t              control;
        logic [`CORE_XLEN-1:0] alu_result;
        logic [`CORE_XLEN-1:0] store_data;
        logic [4:0]            dest_reg;
    } execute_out_t;

    typedef struct packed {
        logic                  write_reg;
        logic [4:0]            dest_reg;
        logic [`CORE_XLEN-1:0] dest_reg_data;
    } write_back_t;

    typedef enum logic [1:0] {
        NONE     = 2'd0,
        FROM_MEM = 2'd1,
        FROM_WB  = 2'd2
    } fwd_sel_t;

    typedef struct packed {
        fwd_sel_t rs_sel;
        fwd_sel_t rt_sel;
    } forward_info_t;

    function automatic logic [`CORE_XLEN-1:0] select_forward(
        input fwd_sel_t              sel,
        input logic [`CORE_XLEN-1:0] mem_data,
        input logic [`CORE_XLEN-1:0] wb_data,
        input logic [`CORE_XLEN-1:0] reg_data
    );
        case (sel)
            FROM_MEM: return mem_data;
            FROM_WB:  return wb_data;
            default:  return reg_data;
        endcase
    endfunction

endpackage

//--- hdl/stage_fetch.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module stage_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  logic                   load_pc,
    input  logic [`CORE_XLEN-1:0]  pc_value,
    output logic [`CORE_XLEN-1:0]  imem_addr,
    input  logic [`CORE_XLEN-1:0]  imem_data,
    output core_pkg::instruction_t instruction,
    output logic [`CORE_XLEN-1:0]  pc_add4
);
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] pc_seq;

    assign pc_seq    = pc + 4;
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `CORE_RESET_PC;
        end else if (!stall) begin
            pc <= load_pc ? pc_value : pc_seq;
        end
    end

    // Zero word decodes as a nop
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instruction <= '0;
            pc_add4     <= '0;
        end else if (!stall) begin
            instruction <= imem_data;
            pc_add4     <= pc_seq;
        end
    end
endmodule

//--- hdl/stage_decode.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module stage_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  core_pkg::instruction_t  instruction,
    input  logic [`CORE_XLEN-1:0]   pc_add4,
    input  core_pkg::write_back_t   wb,
    input  logic [`CORE_XLEN-1:0]   mem_fwd_data,
    input  core_pkg::forward_info_t forward,
    output logic [4:0]              rs,
    output logic [4:0]              rt,
    output logic                    uses_rt,
    output logic                    branch_taken,
    output logic [`CORE_XLEN-1:0]   branch_target,
    output logic                    is_branch,
    output core_pkg::decode_out_t   dout
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];
    control_t              ctrl;
    logic [4:0]            dest;
    logic                  is_jump;
    logic [`CORE_XLEN-1:0] imm_val;
    logic [`CORE_XLEN-1:0] rs_val;
    logic [`CORE_XLEN-1:0] rt_val;
    logic [`CORE_XLEN-1:0] rs_cmp;
    logic [`CORE_XLEN-1:0] rt_cmp;
    logic [`CORE_XLEN-1:0] branch_offset;

    always_ff @(posedge clk) begin
        if (wb.write_reg && wb.dest_reg != 5'd0) begin
            regs[wb.dest_reg] <= wb.dest_reg_data;
        end
    end

    // Write-back value is visible in the same cycle
    assign rs_val = (rs == 5'd0) ? '0 :
                    (wb.write_reg && wb.dest_reg == rs) ? wb.dest_reg_data : regs[rs];
    assign rt_val = (rt == 5'd0) ? '0 :
                    (wb.write_reg && wb.dest_reg == rt) ? wb.dest_reg_data : regs[rt];

    assign rt = instruction.i.rt;

    always_comb begin
        ctrl      = '0;
        dest      = 5'd0;
        rs        = instruction.i.rs;
        uses_rt   = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        imm_val   = {{16{instruction.i.imm[15]}}, instruction.i.imm};
        case (instruction.i.op)
            `OP_SPECIAL: begin
                ctrl.write_reg = 1'b1;
                dest           = instruction.r.rd;
                uses_rt        = 1'b1;
                case (instruction.r.funct)
                    `FN_ADDU: ctrl.alu_op = ADD;
                    `FN_SUBU: ctrl.alu_op = SUB;
                    `FN_AND:  ctrl.alu_op = AND;
                    `FN_OR:   ctrl.alu_op = OR;
                    `FN_SLT:  ctrl.alu_op = SLT;
                    `FN_SLL: begin
                        // Shifted value enters as operand a
                        ctrl.alu_op  = SLL;
                        ctrl.use_imm = 1'b1;
                        rs           = instruction.r.rt;
                        uses_rt      = 1'b0;
                        imm_val      = {{(`CORE_XLEN-5){1'b0}}, instruction.r.shamt};
                    end
                    default: begin
                        ctrl.write_reg = 1'b0;
                        uses_rt        = 1'b0;
                        rs             = 5'd0;
                    end
                endcase
            end
            `OP_ADDIU, `OP_LW, `OP_ORI, `OP_LUI: begin
                ctrl.alu_op    = ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.write_reg = 1'b1;
                ctrl.mem_read  = (instruction.i.op == `OP_LW);
                dest           = instruction.i.rt;
                if (instruction.i.op == `OP_ORI) begin
                    ctrl.alu_op = OR;
                    imm_val     = {16'h0000, instruction.i.imm};
                end else if (instruction.i.op == `OP_LUI) begin
                    ctrl.alu_op = LUI;
                    rs          = 5'd0;
                end
            end
            `OP_SW: begin
                ctrl.alu_op    = ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                uses_rt        = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                is_branch = 1'b1;
                uses_rt   = 1'b1;
            end
            `OP_J: begin
                is_jump = 1'b1;
                rs      = 5'd0;
            end
            default: rs = 5'd0;
        endcase
        // Register 0 is never written
        if (dest == 5'd0) begin
            ctrl.write_reg = 1'b0;
        end
    end

    assign rs_cmp = select_forward(forward.rs_sel, mem_fwd_data, wb.dest_reg_data, rs_val);
    assign rt_cmp = select_forward(forward.rt_sel, mem_fwd_data, wb.dest_reg_data, rt_val);

    assign branch_offset = {{14{instruction.i.imm[15]}}, instruction.i.imm, 2'b00};
    assign branch_target = is_jump ?
        {pc_add4[`CORE_XLEN-1:28], instruction.i.rs, instruction.i.rt, instruction.i.imm, 2'b00} :
        pc_add4 + branch_offset;
    // beq takes on equal, bne on not equal
    assign branch_taken = is_jump ||
        (is_branch && ((instruction.i.op == `OP_BEQ) == (rs_cmp == rt_cmp)));

    always_ff @(posedge clk) begin
        if (!rst_n || stall) begin
            dout <= '0;
        end else begin
            dout.control    <= ctrl;
            dout.operand_a  <= rs_val;
            dout.operand_b  <= imm_val;
            dout.store_data <= rt_val;
            dout.rs         <= rs;
            dout.rt         <= uses_rt ? rt : 5'd0;
            dout.dest_reg   <= dest;
        end
    end
endmodule

//--- hdl/stage_execute.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module stage_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  core_pkg::decode_out_t   din,
    input  core_pkg::forward_info_t forward,
    input  logic [`CORE_XLEN-1:0]   mem_fwd_data,
    input  logic [`CORE_XLEN-1:0]   wb_fwd_data,
    output core_pkg::execute_out_t  dout
);
    import core_pkg::*;

    logic [`CORE_XLEN-1:0] src_a;
    logic [`CORE_XLEN-1:0] rt_val;
    logic [`CORE_XLEN-1:0] src_b;
    logic [`CORE_XLEN-1:0] result;

    assign src_a  = select_forward(forward.rs_sel, mem_fwd_data, wb_fwd_data, din.operand_a);
    assign rt_val = select_forward(forward.rt_sel, mem_fwd_data, wb_fwd_data, din.store_data);
    // Immediate is never bypassed
    assign src_b  = din.control.use_imm ? din.operand_b : rt_val;

    always_comb begin
        result = '0;
        case (din.control.alu_op)
            ADD: result = src_a + src_b;
            SUB: result = src_a - src_b;
            AND: result = src_a & src_b;
            OR:  result = src_a | src_b;
            SLT: result[0] = $signed(src_a) < $signed(src_b);
            SLL: result = src_a << src_b[4:0];
            LUI: result = src_b << 16;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dout <= '0;
        end else begin
            dout.control    <= din.control;
            dout.alu_result <= result;
            dout.store_data <= rt_val;
            dout.dest_reg   <= din.dest_reg;
        end
    end
endmodule

//--- hdl/stage_memory.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module stage_memory (
    input  logic                   clk,
    input  logic                   rst_n,
    input  core_pkg::execute_out_t din,
    output logic [`CORE_XLEN-1:0]  dmem_addr,
    output logic [`CORE_XLEN-1:0]  dmem_wdata,
    output logic                   dmem_we,
    input  logic [`CORE_XLEN-1:0]  dmem_rdata,
    output logic [`CORE_XLEN-1:0]  mem_fwd_data,
    output core_pkg::write_back_t  wb
);
    // Data port answers in the same cycle
    assign dmem_addr  = din.alu_result;
    assign dmem_wdata = din.store_data;
    assign dmem_we    = din.control.mem_write;

    assign mem_fwd_data = din.control.mem_read ? dmem_rdata : din.alu_result;

    // Write-back register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb <= '0;
        end else begin
            wb.write_reg     <= din.control.write_reg;
            wb.dest_reg      <= din.dest_reg;
            wb.dest_reg_data <= mem_fwd_data;
        end
    end
endmodule

//--- hdl/main_forwarder.sv
`timescale 1ns/1ps

module main_forwarder (
    input  logic [4:0]              rs,
    input  logic [4:0]              rt,
    input  logic [4:0]              ex_rs,
    input  logic [4:0]              ex_rt,
    input  core_pkg::execute_out_t  mem_rec,
    input  core_pkg::write_back_t   wb,
    output core_pkg::forward_info_t decode_forward_info,
    output core_pkg::forward_info_t execute_forward_info
);
    import core_pkg::*;

    // Memory stage holds the younger result
    function automatic fwd_sel_t pick(
        input logic [4:0]   src,
        input execute_out_t mem_r,
        input write_back_t  wb_r
    );
        if (src == 5'd0) begin
            return NONE;
        end else if (mem_r.control.write_reg && mem_r.dest_reg == src) begin
            return FROM_MEM;
        end else if (wb_r.write_reg && wb_r.dest_reg == src) begin
            return FROM_WB;
        end
        return NONE;
    endfunction

    always_comb begin
        decode_forward_info.rs_sel  = pick(rs, mem_rec, wb);
        decode_forward_info.rt_sel  = pick(rt, mem_rec, wb);
        execute_forward_info.rs_sel = pick(ex_rs, mem_rec, wb);
        execute_forward_info.rt_sel = pick(ex_rt, mem_rec, wb);
    end
endmodule

//--- hdl/pipeline_flow_controller.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module pipeline_flow_controller (
    input  logic [4:0]             rs,
    input  logic [4:0]             rt,
    input  logic                   uses_rt,
    input  logic                   is_branch,
    input  core_pkg::decode_out_t  ex_rec,
    input  core_pkg::execute_out_t mem_rec,
    input  logic                   branch_taken,
    input  logic [`CORE_XLEN-1:0]  branch_target,
    output logic                   stall,
    output logic                   load_pc,
    output logic [`CORE_XLEN-1:0]  pc_value
);
    logic ex_rs_hit;
    logic ex_rt_hit;
    logic mem_rs_hit;
    logic mem_rt_hit;
    logic load_use;
    logic branch_wait;

    // Writers of register 0 never carry write_reg
    assign ex_rs_hit  = ex_rec.control.write_reg && ex_rec.dest_reg == rs;
    assign ex_rt_hit  = ex_rec.control.write_reg && uses_rt && ex_rec.dest_reg == rt;
    assign mem_rs_hit = mem_rec.control.write_reg && mem_rec.control.mem_read &&
                        mem_rec.dest_reg == rs;
    assign mem_rt_hit = mem_rec.control.write_reg && mem_rec.control.mem_read &&
                        uses_rt && mem_rec.dest_reg == rt;

    assign load_use = ex_rec.control.mem_read && (ex_rs_hit || ex_rt_hit);

    // Branch compares in decode, so its operands must be ready there
    assign branch_wait = is_branch && (ex_rs_hit || ex_rt_hit || mem_rs_hit || mem_rt_hit);

    assign stall    = load_use || branch_wait;
    assign load_pc  = branch_taken && !stall;
    assign pc_value = branch_target;
endmodule

//--- hdl/core.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module core (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [`CORE_XLEN-1:0] imem_addr,
    input  logic [`CORE_XLEN-1:0] imem_data,
    output logic [`CORE_XLEN-1:0] dmem_addr,
    output logic [`CORE_XLEN-1:0] dmem_wdata,
    output logic                  dmem_we,
    input  logic [`CORE_XLEN-1:0] dmem_rdata
);
    import core_pkg::*;

    instruction_t          if_instruction;
    logic [`CORE_XLEN-1:0] if_pc_add4;
    decode_out_t           id_ex;
    execute_out_t          ex_mem;
    write_back_t           mem_wb;
    forward_info_t         decode_fwd;
    forward_info_t         execute_fwd;
    logic [`CORE_XLEN-1:0] mem_fwd_data;
    logic [4:0]            dec_rs;
    logic [4:0]            dec_rt;
    logic                  dec_uses_rt;
    logic                  dec_is_branch;
    logic                  branch_taken;
    logic [`CORE_XLEN-1:0] branch_target;
    logic                  stall;
    logic                  load_pc;
    logic [`CORE_XLEN-1:0] pc_value;

    stage_fetch u_fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall), .load_pc(load_pc), .pc_value(pc_value),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .instruction(if_instruction), .pc_add4(if_pc_add4)
    );

    stage_decode u_decode (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .instruction(if_instruction), .pc_add4(if_pc_add4),
        .wb(mem_wb), .mem_fwd_data(mem_fwd_data), .forward(decode_fwd),
        .rs(dec_rs), .rt(dec_rt), .uses_rt(dec_uses_rt),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .is_branch(dec_is_branch), .dout(id_ex)
    );

    stage_execute u_execute (
        .clk(clk), .rst_n(rst_n), .din(id_ex), .forward(execute_fwd),
        .mem_fwd_data(mem_fwd_data), .wb_fwd_data(mem_wb.dest_reg_data), .dout(ex_mem)
    );

    stage_memory u_memory (
        .clk(clk), .rst_n(rst_n), .din(ex_mem),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata), .mem_fwd_data(mem_fwd_data), .wb(mem_wb)
    );

    main_forwarder u_forwarder (
        .rs(dec_rs), .rt(dec_rt), .ex_rs(id_ex.rs), .ex_rt(id_ex.rt),
        .mem_rec(ex_mem), .wb(mem_wb),
        .decode_forward_info(decode_fwd), .execute_forward_info(execute_fwd)
    );

    // Delay slot is always used, so a resolved branch only loads the PC
    pipeline_flow_controller u_flow_controller (
        .rs(dec_rs), .rt(dec_rt), .uses_rt(dec_uses_rt), .is_branch(dec_is_branch),
        .ex_rec(id_ex), .mem_rec(ex_mem),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .stall(stall), .load_pc(load_pc), .pc_value(pc_value)
    );
endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2) clk = ~clk;
    end
endmodule

//--- sim/tb_core.sv
`timescale 1ns/1ps
`include "core_defs.svh"

module tb_core;
    localparam int NTESTS   = 6;
    localparam int MAXWORDS = 256;
    localparam int MAXSTORE = 32;
    localparam int MAXINIT  = 8;
    localparam logic [31:0] END_ADDR = 32'h0000_03fc;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    // Test table
    string       test_name [NTESTS];
    logic [31:0] prog      [NTESTS][MAXWORDS];
    int          prog_len  [NTESTS];
    logic [31:0] init_addr [NTESTS][MAXINIT];
    logic [31:0] init_data [NTESTS][MAXINIT];
    int          init_cnt  [NTESTS];
    logic [31:0] exp_addr  [NTESTS][MAXSTORE];
    logic [31:0] exp_data  [NTESTS][MAXSTORE];
    int          exp_cnt   [NTESTS];
    int          cur;

    logic [31:0] got_addr [$];
    logic [31:0] got_data [$];
    logic        running;
    logic        done;
    int          limit_cycles;
    int          test_errors;
    int          passed;
    int          failed;

    tb_clock #(.PERIOD_NS(100)) clock_gen (.clk(clk));

    core core_inst (
        .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
        .dmem_rdata(dmem_rdata)
    );

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
        end
    end

    // Store monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (running && !done && dmem_we) begin
            if (dmem_addr == END_ADDR) begin
                done = 1'b1;
            end else begin
                got_addr.push_back(dmem_addr);
                got_data.push_back(dmem_wdata);
            end
        end
    end

    function automatic logic [31:0] rtype(logic [5:0] funct, int rd, int rs, int rt);
        return {`OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic logic [31:0] shift_left(int rd, int rt, int sa);
        return {`OP_SPECIAL, 5'd0, rt[4:0], rd[4:0], sa[4:0], `FN_SLL};
    endfunction

    function automatic logic [31:0] itype(logic [5:0] op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] jump_to(int target);
        return {`OP_J, target[27:2]};
    endfunction

    task automatic begin_test(string name);
        cur = cur + 1;
        test_name[cur] = name;
        prog_len[cur]  = 0;
        init_cnt[cur]  = 0;
        exp_cnt[cur]   = 0;
    endtask

    task automatic emit(logic [31:0] word);
        prog[cur][prog_len[cur]] = word;
        prog_len[cur] += 1;
    endtask

    task automatic preload(logic [31:0] addr, logic [31:0] data);
        init_addr[cur][init_cnt[cur]] = addr;
        init_data[cur][init_cnt[cur]] = data;
        init_cnt[cur] += 1;
    endtask

    task automatic expect_store(logic [31:0] addr, logic [31:0] data);
        exp_addr[cur][exp_cnt[cur]] = addr;
        exp_data[cur][exp_cnt[cur]] = data;
        exp_cnt[cur] += 1;
    endtask

    // Final store marks the end of a program
    task automatic end_program();
        emit(itype(`OP_SW, 0, 0, 32'h3fc));
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] b;
        int          base;

        begin_test("reset_state");
        end_program();

        begin_test("forwarding");
        emit(itype(`OP_ADDIU, 1, 0, 5));
        emit(itype(`OP_ADDIU, 2, 1, 7));
        emit(rtype(`FN_ADDU, 3, 2, 1));
        emit(rtype(`FN_SUBU, 4, 3, 2));
        emit(rtype(`FN_AND, 5, 4, 3));
        emit(rtype(`FN_OR, 6, 5, 3));
        emit(rtype(`FN_SLT, 7, 4, 6));
        emit(shift_left(8, 6, 3));
        emit(rtype(`FN_SUBU, 9, 0, 8));
        emit(rtype(`FN_SLT, 10, 9, 8));
        emit(itype(`OP_SW, 10, 0, 24));
        emit(itype(`OP_SW, 8, 0, 20));
        emit(itype(`OP_SW, 9, 0, 28));
        for (int r = 3; r <= 7; r++) begin
            emit(itype(`OP_SW, r, 0, 4 * (r - 3)));
        end
        end_program();
        expect_store(24, 1);
        expect_store(20, 136);
        expect_store(28, 32'hffff_ff78);
        expect_store(0, 17);
        expect_store(4, 5);
        expect_store(8, 1);
        expect_store(12, 17);
        expect_store(16, 1);

        begin_test("loads_stores");
        preload(32'h40, 32'h1234_5678);
        preload(32'h44, 32'h0000_0100);
        preload(32'h100, 32'hcafe_f00d);
        emit(itype(`OP_LW, 1, 0, 32'h40));
        emit(itype(`OP_ADDIU, 2, 1, 1));
        emit(itype(`OP_LW, 3, 0, 32'h44));
        emit(itype(`OP_LW, 4, 3, 0));
        emit(itype(`OP_SW, 2, 0, 32'h80));
        emit(itype(`OP_LW, 5, 0, 32'h80));
        emit(rtype(`FN_SUBU, 6, 5, 1));
        emit(itype(`OP_SW, 6, 0, 32'h84));
        emit(itype(`OP_SW, 4, 0, 32'h88));
        emit(itype(`OP_LW, 7, 0, 32'h88));
        emit(itype(`OP_SW, 7, 0, 32'h8c));
        end_program();
        expect_store(32'h80, 32'h1234_5679);
        expect_store(32'h84, 1);
        expect_store(32'h88, 32'hcafe_f00d);
        expect_store(32'h8c, 32'hcafe_f00d);

        // Word indices in comments, branch offsets count from the delay slot
        begin_test("branches");
        preload(32'h40, 7);
        emit(itype(`OP_ADDIU, 4, 0, 0));
        emit(itype(`OP_ADDIU, 9, 0, 0));
        emit(itype(`OP_ADDIU, 12, 0, 0));
        emit(itype(`OP_ADDIU, 1, 0, 1));
        emit(itype(`OP_ADDIU, 2, 0, 1));
        emit(itype(`OP_BEQ, 2, 1, 2));          // 5: taken to 8
        emit(itype(`OP_ADDIU, 3, 0, 32'h33));
        emit(itype(`OP_ADDIU, 4, 0, 32'h44));
        emit(itype(`OP_BEQ, 0, 1, 11));         // 8: not taken
        emit(itype(`OP_ADDIU, 5, 0, 32'h55));
        emit(itype(`OP_ADDIU, 6, 0, 32'h66));
        emit(itype(`OP_LW, 7, 0, 32'h40));
        emit(itype(`OP_BNE, 0, 7, 2));          // 12: taken to 15
        emit(itype(`OP_ADDIU, 8, 0, 32'h88));
        emit(itype(`OP_ADDIU, 9, 0, 32'h99));
        emit(itype(`OP_BNE, 2, 1, 4));          // 15: not taken
        emit(itype(`OP_ADDIU, 10, 0, 32'haa));
        emit(jump_to(20 * 4));                  // 17: to 20
        emit(itype(`OP_ADDIU, 11, 0, 32'hbb));
        emit(itype(`OP_ADDIU, 12, 0, 32'hcc));
        for (int r = 3; r <= 12; r++) begin
            emit(itype(`OP_SW, r, 0, 32'h100 + 4 * (r - 3)));
        end
        end_program();
        expect_store(32'h100, 32'h33);
        expect_store(32'h104, 0);
        expect_store(32'h108, 32'h55);
        expect_store(32'h10c, 32'h66);
        expect_store(32'h110, 7);
        expect_store(32'h114, 32'h88);
        expect_store(32'h118, 0);
        expect_store(32'h11c, 32'haa);
        expect_store(32'h120, 32'hbb);
        expect_store(32'h124, 0);

        begin_test("register_zero");
        preload(32'h40, 32'hffff_ffff);
        emit(itype(`OP_ADDIU, 1, 0, 3));
        emit(itype(`OP_ADDIU, 0, 0, 32'h55));
        emit(rtype(`FN_ADDU, 0, 1, 1));
        emit(itype(`OP_LW, 0, 0, 32'h40));
        emit(itype(`OP_SW, 0, 0, 32'h200));
        emit(rtype(`FN_ADDU, 2, 0, 1));
        emit(itype(`OP_SW, 2, 0, 32'h204));
        end_program();
        expect_store(32'h200, 0);
        expect_store(32'h204, 3);

        begin_test("random_operands");
        for (int j = 0; j < 10; j++) begin
            a    = $urandom();
            b    = $urandom();
            base = 32'h300 + 12 * j;
            emit(itype(`OP_LUI, 1, 0, a >> 16));
            emit(itype(`OP_ORI, 1, 1, a));
            emit(itype(`OP_LUI, 2, 0, b >> 16));
            emit(itype(`OP_ORI, 2, 2, b));
            emit(rtype(`FN_ADDU, 3, 1, 2));
            emit(rtype(`FN_SUBU, 4, 1, 2));
            emit(rtype(`FN_SLT, 5, 1, 2));
            emit(itype(`OP_SW, 3, 0, base));
            emit(itype(`OP_SW, 4, 0, base + 4));
            emit(itype(`OP_SW, 5, 0, base + 8));
            expect_store(base, a + b);
            expect_store(base + 4, a - b);
            expect_store(base + 8, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        end
        end_program();
    endtask

    task automatic load_memories(int t);
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = 32'hd000_0000 | (i << 2);
        end
        for (int k = 0; k < prog_len[t]; k++) begin
            imem[k] = prog[t][k];
        end
        for (int k = 0; k < init_cnt[t]; k++) begin
            dmem[init_addr[t][k][9:2]] = init_data[t][k];
        end
    endtask

    task automatic check_we_low(int t);
        if (dmem_we) begin
            $display("** Error %s: dmem_we around reset expected 0, actual %0b",
                     test_name[t], dmem_we);
            test_errors++;
        end
    endtask

    task automatic check_pc_reset(int t);
        if (imem_addr != `CORE_RESET_PC) begin
            $display("** Error %s: imem_addr in reset expected 0x%08h, actual 0x%08h",
                     test_name[t], `CORE_RESET_PC, imem_addr);
            test_errors++;
        end
    endtask

    task automatic run_test(int t);
        int n;
        test_errors = 0;
        @(posedge clk);
        #1 rst_n = 1'b0;
        for (int k = 0; k < 4; k++) begin
            @(posedge clk);
            #1;
            if (k == 0) begin
                load_memories(t);
            end
            if (k == 3) begin
                rst_n = 1'b1;
            end
            check_we_low(t);
            check_pc_reset(t);
        end
        @(posedge clk);
        #1;
        check_we_low(t);
        got_addr.delete();
        got_data.delete();
        done    = 1'b0;
        running = 1'b1;
        wait (done);
        running = 1'b0;
        if (got_addr.size() != exp_cnt[t]) begin
            $display("** Error %s: store count expected %0d, actual %0d",
                     test_name[t], exp_cnt[t], got_addr.size());
            test_errors++;
        end
        n = (got_addr.size() < exp_cnt[t]) ? got_addr.size() : exp_cnt[t];
        for (int k = 0; k < n; k++) begin
            if (got_addr[k] != exp_addr[t][k] || got_data[k] != exp_data[t][k]) begin
                $display("** Error %s: store %0d expected 0x%08h at 0x%08h, %s",
                         test_name[t], k, exp_data[t][k], exp_addr[t][k],
                         $sformatf("actual 0x%08h at 0x%08h", got_data[k], got_addr[k]));
                test_errors++;
            end
        end
        if (test_errors == 0) begin
            passed++;
            $display("Test %s: passed, %0d stores checked", test_name[t], n);
        end else begin
            failed++;
            $display("Test %s: failed with %0d errors", test_name[t], test_errors);
        end
    endtask

    initial begin
        int words;
        rst_n        = 1'b0;
        running      = 1'b0;
        done         = 1'b0;
        cur          = -1;
        passed       = 0;
        failed       = 0;
        limit_cycles = 0;
        words        = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
            dmem[i] = 32'hd000_0000 | (i << 2);
        end
        void'($urandom(32'h7d9f));
        build_table();
        for (int t = 0; t < NTESTS; t++) begin
            words += prog_len[t];
        end
        limit_cycles = 64 * words + 200;
        for (int t = 0; t < NTESTS; t++) begin
            run_test(t);
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d", NTESTS, passed, failed);
        if (failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: a program did not reach its final store within %0d cycles",
                 limit_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end
endmodule

//--- vlog.f
+incdir+hdl
hdl/core_pkg.sv
hdl/stage_fetch.sv
hdl/stage_decode.sv
hdl/stage_execute.sv
hdl/stage_memory.sv
hdl/main_forwarder.sv
hdl/pipeline_flow_controller.sv
hdl/core.sv
sim/tb_clock.sv
sim/tb_core.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f vlog.f --top-module tb_core -Mdir obj_dir -o sim_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "Failures reported in $LOG"
    exit 1
fi
exit 0
